//--- dv/knn_patch_match_props.sv
`timescale 1ns/10ps
`default_nettype none

module knn_patch_match_props (
    input logic                                         clk,
    input logic                                         rst_n,
    input logic                                         wb_cyc,
    input logic                                         wb_stb,
    input logic                                         wb_ack,
    input logic                                         done,
    input knn_cfg_pkg::dist_t [knn_cfg_pkg::k_best-1:0] res_dist
);
    import knn_cfg_pkg::*;

    logic ranked;

    always_comb begin
        ranked = 1'b1;
        for (int r = 1; r < k_best; r++) begin
            if (res_dist[r] < res_dist[r-1]) ranked = 1'b0;    // rank order broken
        end
    end

    ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("ack raised without a request in the cycle before");

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack)
        else $error("ack held for two cycles");

    // results land on the same edge as done
    results_ordered: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> ranked)
        else $error("result distances not ascending when done rose");

endmodule

bind knn_patch_match knn_patch_match_props u_props (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .done     (u_decode.done),
    .res_dist (u_decode.res_dist)
);

`default_nettype wire

//--- dv/knn_patch_match_tb.sv
`timescale 1ns/10ps
`default_nettype none

module knn_patch_match_tb;
    import knn_cfg_pkg::*;
    import knn_bus_pkg::*;

    localparam int ack_limit  = 20;     // cycles per bus request
    localparam int done_limit = 40;     // status polls

    logic                     clk;
    logic                     rst_n;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [31:0]              wb_dat_w;
    logic [31:0]              wb_dat_r;
    logic                     wb_ack;

    // reference model state
    int cand [leaf_size][patch_size];
    int query [patch_size];
    int patch_a [patch_size];
    int leaf;
    int run_dist [leaf_size];
    int run_idx [leaf_size];

    bit run_ended;
    bit fail_printed;

    knn_patch_match uut (.*);

    always #20 clk = ~clk;

    task automatic fail_now(input string why);
        fail_printed = 1'b1;
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_now($sformatf("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp));
    endtask

    task automatic bus_cycle(input logic we, input logic [wb_addr_width-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int n;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= adr;
        wb_dat_w <= wdata;
        n = 0;
        do begin
            @(posedge clk);
            n++;
            if (n > ack_limit) fail_now($sformatf("no ack for address 0x%02h", adr));
        end while (!wb_ack);
        rdata = wb_dat_r;   // valid with ack
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic write_reg(input logic [wb_addr_width-1:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input logic [wb_addr_width-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, 32'h0, data);
    endtask

    task automatic expect_reg(input string name, input logic [wb_addr_width-1:0] adr,
                              input logic [31:0] exp);
        logic [31:0] got;
        read_reg(adr, got);
        check_eq(name, got, exp);
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int n;
        n = 0;
        do begin
            read_reg(addr_status, st);
            n++;
            if (!st[status_done_bit] && n >= done_limit) begin
                fail_now("done never set after the last query");
            end
        end while (!st[status_done_bit]);
    endtask

    function automatic int rand_elem();
        return int'($urandom % 31) - 15;    // -15 .. 15
    endfunction

    function automatic int lane_distance(int l);
        int s;
        int d;
        s = 0;
        for (int e = 0; e < patch_size; e++) begin
            d = cand[l][e] - query[e];
            s += d * d;
        end
        return (s > dist_max) ? dist_max : s;
    endfunction

    task automatic write_candidates();
        for (int l = 0; l < leaf_size; l++)
            for (int e = 0; e < patch_size; e++)
                write_reg(addr_cand_base + wb_addr_width'(l * 8 + e), cand[l][e]);
    endtask

    task automatic write_query();
        for (int e = 0; e < patch_size; e++)
            write_reg(addr_query_base + wb_addr_width'(e), query[e]);
    endtask

    task automatic set_leaf(input int v);
        leaf = v;
        write_reg(addr_leaf_idx, v);
    endtask

    // command plus the matching running-minimum update in the model
    task automatic issue_query(input bit first, input bit last);
        int d;
        write_reg(addr_cmd, {29'b0, last, first, 1'b1});
        for (int l = 0; l < leaf_size; l++) begin
            d = lane_distance(l);
            if (first || d < run_dist[l]) begin
                run_dist[l] = d;
                run_idx[l]  = leaf * leaf_size + l;
            end
        end
    endtask

    task automatic check_results();
        int d [leaf_size];
        int x [leaf_size];
        int t;
        for (int l = 0; l < leaf_size; l++) begin
            d[l] = run_dist[l];
            x[l] = run_idx[l];
        end
        for (int i = 0; i < leaf_size - 1; i++) begin
            for (int j = i + 1; j < leaf_size; j++) begin
                if (d[j] < d[i] || (d[j] == d[i] && x[j] < x[i])) begin
                    t = d[i];
                    d[i] = d[j];
                    d[j] = t;
                    t = x[i];
                    x[i] = x[j];
                    x[j] = t;
                end
            end
        end
        for (int r = 0; r < k_best; r++)
            expect_reg($sformatf("result[%0d]", r), addr_result_base + wb_addr_width'(r),
                       32'(d[r]) | (32'(x[r]) << result_idx_lsb));
    endtask

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        void'($urandom(7763));
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        expect_reg("status", addr_status, 32'h0);
        for (int r = 0; r < k_best; r++)
            expect_reg($sformatf("result[%0d]", r), addr_result_base + wb_addr_width'(r), 32'h0);

        // element and leaf read-back, sign extended
        foreach (cand[l, e]) cand[l][e] = rand_elem();
        foreach (query[e]) query[e] = rand_elem();
        write_candidates();
        write_query();
        foreach (cand[l, e])
            expect_reg($sformatf("cand[%0d][%0d]", l, e),
                       addr_cand_base + wb_addr_width'(l * 8 + e), 32'(cand[l][e]));
        foreach (query[e])
            expect_reg($sformatf("query[%0d]", e), addr_query_base + wb_addr_width'(e),
                       32'(query[e]));
        set_leaf(37);
        expect_reg("leaf_idx", addr_leaf_idx, 32'd37);

        // single query
        issue_query(1'b1, 1'b1);
        wait_done();
        check_results();

        // three queries, third repeats the first patch for ties
        foreach (patch_a[e]) patch_a[e] = rand_elem();
        query = patch_a;
        write_query();
        set_leaf(5);
        issue_query(1'b1, 1'b0);
        expect_reg("status", addr_status, 32'h0);   // first flag clears done
        foreach (query[e]) query[e] = rand_elem();
        write_query();
        set_leaf(9);
        issue_query(1'b0, 1'b0);
        query = patch_a;
        write_query();
        set_leaf(13);
        issue_query(1'b0, 1'b1);
        wait_done();
        check_results();

        // every element opposite in sign, all lanes saturate
        foreach (cand[l, e]) cand[l][e] = (e % 2) ? 15 : -15;
        foreach (query[e]) query[e] = (e % 2) ? -15 : 15;
        write_candidates();
        write_query();
        set_leaf(63);
        issue_query(1'b1, 1'b1);
        expect_reg("status", addr_status, 32'h0);
        wait_done();
        check_results();

        run_ended = 1'b1;
        $display("STATUS: PASS");
        $finish;
    end

    // stopped early by a bound assertion
    final begin
        if (!run_ended && !fail_printed) $display("STATUS: FAIL");
    end

endmodule

`default_nettype wire

//--- knn_patch_match.f
src/knn_cfg_pkg.sv
src/knn_bus_pkg.sv
src/knn_wb_decode.sv
src/l2_dist_kernel.sv
src/lane_running_min.sv
src/bitonic_top4.sv
src/knn_patch_match.sv
dv/knn_patch_match_props.sv
dv/knn_patch_match_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, then judge the run from its log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f knn_patch_match.f \
    --top-module knn_patch_match_tb -o knn_sim || { echo "build failed"; exit 1; }
./obj_dir/knn_sim > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && echo "simulation failed" && exit 1
# a run stopped by an assertion never reaches the pass line
grep -q "STATUS: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0

//--- src/bitonic_top4.sv
`timescale 1ns/10ps
`default_nettype none

module bitonic_top4 (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                run_valid,
    input  knn_cfg_pkg::dist_t [knn_cfg_pkg::leaf_size-1:0]     min_dist,
    input  knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::leaf_size-1:0] min_idx,
    output logic                                                best_valid,
    output knn_cfg_pkg::dist_t [knn_cfg_pkg::k_best-1:0]        best_dist,
    output knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::k_best-1:0]    best_idx
);
    import knn_cfg_pkg::*;

    dist_t     d1 [leaf_size];
    cand_idx_t x1 [leaf_size];
    dist_t     s1_dist [leaf_size];
    cand_idx_t s1_idx  [leaf_size];
    dist_t     d2 [k_best];
    cand_idx_t x2 [k_best];
    dist_t     s2_dist [k_best];
    cand_idx_t s2_idx  [k_best];
    dist_t     d3 [k_best];
    cand_idx_t x3 [k_best];
    logic      s1_valid;
    logic      s2_valid;

    // distance first, lower index breaks a tie
    function automatic logic precedes(dist_t da, cand_idx_t ia, dist_t db, cand_idx_t ib);
        return (da < db) || ((da == db) && (ia < ib));
    endfunction

    function automatic void cex(inout dist_t da, inout cand_idx_t ia,
                                inout dist_t db, inout cand_idx_t ib, input logic up);
        dist_t     td;
        cand_idx_t ti;
        td = da;
        ti = ia;
        if (up ? precedes(db, ib, da, ia) : precedes(da, ia, db, ib)) begin
            da = db;
            ia = ib;
            db = td;
            ib = ti;
        end
    endfunction

    // sort the low four up, the high four down
    always_comb begin
        int b;
        for (int i = 0; i < leaf_size; i++) begin
            d1[i] = min_dist[i];
            x1[i] = min_idx[i];
        end
        for (int g = 0; g < 2; g++) begin
            b = g * k_best;
            cex(d1[b], x1[b], d1[b+1], x1[b+1], 1'b1);
            cex(d1[b+2], x1[b+2], d1[b+3], x1[b+3], 1'b0);
            cex(d1[b], x1[b], d1[b+2], x1[b+2], g == 0);
            cex(d1[b+1], x1[b+1], d1[b+3], x1[b+3], g == 0);
            cex(d1[b], x1[b], d1[b+1], x1[b+1], g == 0);
            cex(d1[b+2], x1[b+2], d1[b+3], x1[b+3], g == 0);
        end
    end

    // half cleaner, lower half keeps the four smallest as a bitonic run
    always_comb begin
        for (int i = 0; i < k_best; i++) begin
            if (precedes(s1_dist[i+k_best], s1_idx[i+k_best], s1_dist[i], s1_idx[i])) begin
                d2[i] = s1_dist[i+k_best];
                x2[i] = s1_idx[i+k_best];
            end else begin
                d2[i] = s1_dist[i];
                x2[i] = s1_idx[i];
            end
        end
    end

    always_comb begin
        d3 = s2_dist;
        x3 = s2_idx;
        cex(d3[0], x3[0], d3[2], x3[2], 1'b1);
        cex(d3[1], x3[1], d3[3], x3[3], 1'b1);
        cex(d3[0], x3[0], d3[1], x3[1], 1'b1);
        cex(d3[2], x3[2], d3[3], x3[3], 1'b1);
    end

    always_ff @(posedge clk) begin
        s1_dist <= d1;
        s1_idx  <= x1;
        s2_dist <= d2;
        s2_idx  <= x2;
        for (int i = 0; i < k_best; i++) begin
            best_dist[i] <= d3[i];
            best_idx[i]  <= x3[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s2_valid   <= 1'b0;
            best_valid <= 1'b0;
        end else begin
            s1_valid   <= run_valid;
            s2_valid   <= s1_valid;
            best_valid <= s2_valid;
        end
    end

endmodule

`default_nettype wire

//--- src/knn_bus_pkg.sv
`default_nettype none

package knn_bus_pkg;

    localparam int wb_addr_width = 7;   // word addresses
    localparam int wb_data_width = 32;

    // register map
    localparam logic [wb_addr_width-1:0] addr_cand_base   = 7'h00; // lane*8 + elem
    localparam logic [wb_addr_width-1:0] addr_query_base  = 7'h40;
    localparam logic [wb_addr_width-1:0] addr_leaf_idx    = 7'h48;
    localparam logic [wb_addr_width-1:0] addr_cmd         = 7'h49;
    localparam logic [wb_addr_width-1:0] addr_result_base = 7'h50; // ranks 0..3
    localparam logic [wb_addr_width-1:0] addr_status      = 7'h54;

    // result word: distance at the bottom, index from here up
    localparam int result_idx_lsb  = 16;
    localparam int status_done_bit = 0;

    typedef struct packed {
        logic [wb_data_width-knn_cfg_pkg::data_width-1:0] pad;
        knn_cfg_pkg::elem_t                               value;
    } elem_view_t;

    typedef struct packed {
        logic [wb_data_width-4:0] pad;
        logic                     last;
        logic                     first;
        logic                     start;
    } cmd_view_t;

    // one write word, element or command depending on address
    typedef union packed {
        elem_view_t elem;
        cmd_view_t  cmd;
    } wr_word_u;

endpackage

`default_nettype wire

//--- src/knn_cfg_pkg.sv
`default_nettype none

package knn_cfg_pkg;

    localparam int data_width      = 11;
    localparam int patch_size      = 5;     // elements per patch
    localparam int leaf_size       = 8;     // candidates per leaf, one lane each
    localparam int k_best          = 4;
    localparam int num_leaves      = 64;

    localparam int leaf_addr_width = $clog2(num_leaves);
    localparam int lane_width      = $clog2(leaf_size);
    localparam int index_width     = leaf_addr_width + lane_width;

    // distances saturate at the top of the element range
    localparam int dist_max        = (1 << data_width) - 1;

    // kernel arithmetic
    localparam int diff_width      = data_width + 1;
    localparam int sq_width        = 2 * data_width;    // holds 2047 squared
    localparam int sum_width       = sq_width + $clog2(patch_size);

    typedef logic signed [data_width-1:0] elem_t;
    typedef logic [data_width-1:0]        dist_t;
    typedef logic [index_width-1:0]       cand_idx_t;

endpackage

`default_nettype wire

//--- src/knn_patch_match.sv
`timescale 1ns/10ps
`default_nettype none

module knn_patch_match (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [knn_bus_pkg::wb_addr_width-1:0]   wb_adr,
    input  logic [knn_bus_pkg::wb_data_width-1:0]   wb_dat_w,
    output logic [knn_bus_pkg::wb_data_width-1:0]   wb_dat_r,
    output logic                                    wb_ack
);
    import knn_cfg_pkg::*;

    // host side registers into the kernel
    elem_t [leaf_size-1:0][patch_size-1:0]  cand_patches;
    elem_t [patch_size-1:0]                 query_patch;
    logic [leaf_addr_width-1:0]             leaf_idx;
    logic                                   query_valid;
    logic                                   query_first;
    logic                                   query_last;

    logic                                   dist_valid;
    logic                                   dist_first;
    logic                                   dist_last;
    dist_t [leaf_size-1:0]                  lane_dist;
    cand_idx_t [leaf_size-1:0]              lane_idx;

    logic                                   run_valid;
    dist_t [leaf_size-1:0]                  min_dist;
    cand_idx_t [leaf_size-1:0]              min_idx;

    logic                                   best_valid;     // back to the register map
    dist_t [k_best-1:0]                     best_dist;
    cand_idx_t [k_best-1:0]                 best_idx;

    knn_wb_decode u_decode (.*);

    l2_dist_kernel u_kernel (.*);

    lane_running_min u_run_min (.*);

    bitonic_top4 u_sorter (.*);

endmodule

`default_nettype wire

//--- src/knn_wb_decode.sv
`timescale 1ns/10ps
`default_nettype none

module knn_wb_decode (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        wb_cyc,
    input  logic                                        wb_stb,
    input  logic                                        wb_we,
    input  logic [knn_bus_pkg::wb_addr_width-1:0]       wb_adr,
    input  logic [knn_bus_pkg::wb_data_width-1:0]       wb_dat_w,
    output logic [knn_bus_pkg::wb_data_width-1:0]       wb_dat_r,
    output logic                                        wb_ack,
    input  logic                                        best_valid,
    input  knn_cfg_pkg::dist_t [knn_cfg_pkg::k_best-1:0]     best_dist,
    input  knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::k_best-1:0] best_idx,
    output knn_cfg_pkg::elem_t [knn_cfg_pkg::leaf_size-1:0][knn_cfg_pkg::patch_size-1:0]
                                                        cand_patches,
    output knn_cfg_pkg::elem_t [knn_cfg_pkg::patch_size-1:0] query_patch,
    output logic [knn_cfg_pkg::leaf_addr_width-1:0]     leaf_idx,
    output logic                                        query_valid,
    output logic                                        query_first,
    output logic                                        query_last
);
    import knn_cfg_pkg::*;
    import knn_bus_pkg::*;

    wr_word_u                     wr_word;
    logic                         req;
    logic                         wr_req;
    logic                         cmd_start;
    logic [lane_width-1:0]        lane_sel;
    logic [2:0]                   elem_sel;
    logic [$clog2(k_best)-1:0]    rank_sel;
    logic                         elem_ok;
    logic                         is_cand;
    logic                         is_query;
    logic                         is_result;
    dist_t [k_best-1:0]           res_dist;
    cand_idx_t [k_best-1:0]       res_idx;
    logic                         done;
    logic [wb_data_width-1:0]     rd_data;

    function automatic logic [wb_data_width-1:0] sext(elem_t e);
        return wb_data_width'(e);
    endfunction

    assign req       = wb_cyc & wb_stb & ~wb_ack;   // ack low, so a fresh request
    assign wr_req    = req & wb_we;
    assign wr_word   = wb_dat_w;
    assign lane_sel  = wb_adr[5:3];     // eight words per candidate
    assign elem_sel  = wb_adr[2:0];
    assign rank_sel  = wb_adr[$clog2(k_best)-1:0];
    assign elem_ok   = elem_sel < patch_size;
    assign is_cand   = (wb_adr[6] == addr_cand_base[6]) && elem_ok;
    assign is_query  = (wb_adr[6:3] == addr_query_base[6:3]) && elem_ok;
    assign is_result = wb_adr[6:2] == addr_result_base[6:2];
    assign cmd_start = wr_req && (wb_adr == addr_cmd) && wr_word.cmd.start;

    always_comb begin
        rd_data = '0;   // unmapped and write-only read as zero
        if (is_cand) begin
            rd_data = sext(cand_patches[lane_sel][elem_sel]);
        end else if (is_query) begin
            rd_data = sext(query_patch[elem_sel]);
        end else if (wb_adr == addr_leaf_idx) begin
            rd_data[leaf_addr_width-1:0] = leaf_idx;
        end else if (is_result) begin
            rd_data[data_width-1:0] = res_dist[rank_sel];
            rd_data[result_idx_lsb +: index_width] = res_idx[rank_sel];
        end else if (wb_adr == addr_status) begin
            rd_data[status_done_bit] = done;
        end
    end

    always_ff @(posedge clk) begin
        if (req) wb_dat_r <= rd_data;
        if (wr_req && is_cand) cand_patches[lane_sel][elem_sel] <= wr_word.elem.value;
        if (wr_req && is_query) query_patch[elem_sel] <= wr_word.elem.value;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack      <= 1'b0;
            query_valid <= 1'b0;
            query_first <= 1'b0;
            query_last  <= 1'b0;
            leaf_idx    <= '0;
            done        <= 1'b0;
            res_dist    <= '0;
            res_idx     <= '0;
        end else begin
            wb_ack      <= req;
            query_valid <= cmd_start;   // leaves with the command's ack
            if (cmd_start) begin
                query_first <= wr_word.cmd.first;
                query_last  <= wr_word.cmd.last;
                if (wr_word.cmd.first) done <= 1'b0;
            end
            if (wr_req && wb_adr == addr_leaf_idx) leaf_idx <= wb_dat_w[leaf_addr_width-1:0];
            if (best_valid) begin
                res_dist <= best_dist;
                res_idx  <= best_idx;
                done     <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/l2_dist_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module l2_dist_kernel (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        query_valid,
    input  logic                                        query_first,
    input  logic                                        query_last,
    input  knn_cfg_pkg::elem_t [knn_cfg_pkg::patch_size-1:0] query_patch,
    input  knn_cfg_pkg::elem_t [knn_cfg_pkg::leaf_size-1:0][knn_cfg_pkg::patch_size-1:0]
                                                        cand_patches,
    input  logic [knn_cfg_pkg::leaf_addr_width-1:0]     leaf_idx,
    output logic                                        dist_valid,
    output logic                                        dist_first,
    output logic                                        dist_last,
    output knn_cfg_pkg::dist_t [knn_cfg_pkg::leaf_size-1:0]     lane_dist,
    output knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::leaf_size-1:0] lane_idx
);
    import knn_cfg_pkg::*;

    logic [sq_width-1:0]        sq_d [leaf_size][patch_size];
    logic [sq_width-1:0]        sq_q [leaf_size][patch_size];
    logic [sum_width-1:0]       sum_d [leaf_size];
    logic [leaf_addr_width-1:0] s1_leaf;
    logic                       s1_valid;
    logic                       s1_first;
    logic                       s1_last;

    // stage one, element differences squared
    always_comb begin
        logic signed [diff_width-1:0] diff;
        for (int l = 0; l < leaf_size; l++) begin
            for (int e = 0; e < patch_size; e++) begin
                diff = diff_width'(cand_patches[l][e]) - diff_width'(query_patch[e]);
                sq_d[l][e] = diff * diff;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (query_valid) begin
            sq_q    <= sq_d;
            s1_leaf <= leaf_idx;
        end
    end

    // stage two, sum per lane
    always_comb begin
        for (int l = 0; l < leaf_size; l++) begin
            sum_d[l] = '0;
            for (int e = 0; e < patch_size; e++) sum_d[l] += sum_width'(sq_q[l][e]);
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int l = 0; l < leaf_size; l++) begin
                lane_dist[l] <= (sum_d[l] > sum_width'(dist_max)) ? dist_t'(dist_max)
                                                                 : sum_d[l][data_width-1:0];
                lane_idx[l]  <= {s1_leaf, lane_width'(l)};  // leaf*8 + lane
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid   <= 1'b0;
            s1_first   <= 1'b0;
            s1_last    <= 1'b0;
            dist_valid <= 1'b0;
            dist_first <= 1'b0;
            dist_last  <= 1'b0;
        end else begin
            s1_valid   <= query_valid;
            s1_first   <= query_first;
            s1_last    <= query_last;
            dist_valid <= s1_valid;
            dist_first <= s1_first;
            dist_last  <= s1_last;
        end
    end

endmodule

`default_nettype wire

//--- src/lane_running_min.sv
`timescale 1ns/10ps
`default_nettype none

module lane_running_min (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                dist_valid,
    input  logic                                                dist_first,
    input  logic                                                dist_last,
    input  knn_cfg_pkg::dist_t [knn_cfg_pkg::leaf_size-1:0]     lane_dist,
    input  knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::leaf_size-1:0] lane_idx,
    output logic                                                run_valid,
    output knn_cfg_pkg::dist_t [knn_cfg_pkg::leaf_size-1:0]     min_dist,
    output knn_cfg_pkg::cand_idx_t [knn_cfg_pkg::leaf_size-1:0] min_idx
);
    import knn_cfg_pkg::*;

    logic [leaf_size-1:0] take;

    // strictly smaller only, so a tie keeps the earlier query's entry
    always_comb begin
        for (int l = 0; l < leaf_size; l++) begin
            take[l] = dist_valid && (dist_first || (lane_dist[l] < min_dist[l]));
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < leaf_size; l++) begin
            if (take[l]) begin
                min_dist[l] <= lane_dist[l];
                min_idx[l]  <= lane_idx[l];
            end
        end
    end

    // minimum registers already hold the last query when this fires
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_valid <= 1'b0;
        end else begin
            run_valid <= dist_valid & dist_last;
        end
    end

endmodule

`default_nettype wire
